// ==== cachePkg.sv ====
`include "cache_consts.svh"

package cachePkg;

    // Load and store sizes, encoded as RISC-V funct3
    typedef enum logic [2:0] {
        sizeByte  = 3'b000,    // lb / sb
        sizeHalf  = 3'b001,    // lh / sh
        sizeWord  = 3'b010,    // lw / sw
        sizeByteU = 3'b100,    // lbu
        sizeHalfU = 3'b101     // lhu
    } accessSize;

    // Core request, held steady while stall is high
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] addr;
        logic [`DATA_WIDTH-1:0] wData;
        logic                   write;
        logic                   read;
        accessSize              size;
    } cpuReq;

    // One queued write to main memory
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] addr;    // Word aligned
        logic [`DATA_WIDTH-1:0] data;
    } memWrite;

endpackage

// ==== cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Core data and address width
`define DATA_WIDTH 32

// Cache geometry, one word per line
`define NUM_SETS 4
`define NUM_WAYS 2
`define SET_BITS 2
`define OFFSET_BITS 2

// Tag is everything above set index and byte offset
`define TAG_BITS (`DATA_WIDTH - `SET_BITS - `OFFSET_BITS)

// Pending memory writes
`define WB_DEPTH 4

// Uncached I/O word
`define MMIO_ADDR 32'h000000FC

`endif

// ==== dataCache.sv ====
`timescale 1ns/100ps
`include "cache_consts.svh"

module dataCache
    import cachePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  cpuReq                  req,
    input  logic [`DATA_WIDTH-1:0] memRData,
    input  logic                   bufFull,
    input  logic                   bufEmpty,
    output logic                   stall,
    output logic                   hit,
    output logic [`DATA_WIDTH-1:0] loadData,
    output logic                   memRd,
    output logic [`DATA_WIDTH-1:0] memRAddr,
    output logic                   push,
    output memWrite                pushEntry
);

    // Line state, control bits carry reset
    logic validQ [`NUM_SETS][`NUM_WAYS];
    logic dirtyQ [`NUM_SETS][`NUM_WAYS];
    logic lruQ   [`NUM_SETS];    // Way to replace next

    logic [`TAG_BITS-1:0]   tagMem  [`NUM_SETS][`NUM_WAYS];
    logic [`DATA_WIDTH-1:0] dataMem [`NUM_SETS][`NUM_WAYS];

    logic [`TAG_BITS-1:0]    reqTag;
    logic [`SET_BITS-1:0]    reqSet;
    logic [`OFFSET_BITS-1:0] reqOffset;

    logic                   reqActive;
    logic                   isIo;
    logic                   hit0;
    logic                   hit1;
    logic                   cacheHit;
    logic                   cacheMiss;
    logic                   hitWay;
    logic [`DATA_WIDTH-1:0] hitData;
    logic                   victimWay;
    logic                   victimDirty;
    logic                   refill;
    logic                   ioLoad;
    logic                   ioStore;
    logic [`DATA_WIDTH-1:0] rdWord;
    logic [`DATA_WIDTH-1:0] storeWord;

    assign reqTag    = req.addr[`DATA_WIDTH-1 -: `TAG_BITS];
    assign reqSet    = req.addr[`OFFSET_BITS +: `SET_BITS];
    assign reqOffset = req.addr[`OFFSET_BITS-1:0];

    assign reqActive = req.read || req.write;
    assign isIo      = (req.addr == `MMIO_ADDR);
    assign ioLoad    = reqActive && isIo && req.read;
    assign ioStore   = reqActive && isIo && req.write;

    // Tag compare on both ways
    assign hit0 = validQ[reqSet][0] && (tagMem[reqSet][0] == reqTag);
    assign hit1 = validQ[reqSet][1] && (tagMem[reqSet][1] == reqTag);

    assign cacheHit  = reqActive && !isIo && (hit0 || hit1);
    assign cacheMiss = reqActive && !isIo && !(hit0 || hit1);
    assign hitWay    = !hit0;
    assign hitData   = dataMem[reqSet][hitWay];

    // Empty ways are filled before LRU replacement kicks in
    always_comb begin
        if (!validQ[reqSet][0]) begin
            victimWay = 1'b0;
        end else if (!validQ[reqSet][1]) begin
            victimWay = 1'b1;
        end else begin
            victimWay = lruQ[reqSet];
        end
    end

    assign victimDirty = validQ[reqSet][victimWay] && dirtyQ[reqSet][victimWay];

    // An empty buffer also has room for the victim
    assign refill = cacheMiss && bufEmpty;

    assign hit      = cacheHit;
    assign stall    = cacheMiss || (ioStore && bufFull);
    assign memRd    = refill || ioLoad;
    assign memRAddr = {req.addr[`DATA_WIDTH-1:`OFFSET_BITS], {`OFFSET_BITS{1'b0}}};
    assign push     = (refill && victimDirty) || (ioStore && !bufFull);

    always_comb begin
        if (ioStore) begin
            pushEntry.addr = memRAddr;    // I/O register is a full word
            pushEntry.data = req.wData;
        end else begin
            // Victim address rebuilt from stored tag
            pushEntry.addr = {tagMem[reqSet][victimWay], reqSet, {`OFFSET_BITS{1'b0}}};
            pushEntry.data = dataMem[reqSet][victimWay];
        end
    end

    // Word handed to the aligner
    always_comb begin
        if (ioLoad) begin
            rdWord = memRData;
        end else if (cacheHit && req.read) begin
            rdWord = hitData;
        end else begin
            rdWord = '0;
        end
    end

    loadAlign loadAlign_inst (
        .word       (rdWord),
        .byteOffset (reqOffset),
        .size       (req.size),
        .data       (loadData)
    );

    // Store merge into the hitting line
    always_comb begin
        storeWord = hitData;
        case (req.size)
            sizeByte: storeWord[8*reqOffset +: 8] = req.wData[7:0];
            sizeHalf: storeWord[16*reqOffset[1] +: 16] = req.wData[15:0];
            sizeWord: storeWord = req.wData;
            default:  storeWord = hitData;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < `NUM_SETS; s++) begin
                lruQ[s] <= 1'b0;
                for (int w = 0; w < `NUM_WAYS; w++) begin
                    validQ[s][w] <= 1'b0;
                    dirtyQ[s][w] <= 1'b0;
                end
            end
        end else begin
            if (refill) begin
                validQ[reqSet][victimWay] <= 1'b1;
                dirtyQ[reqSet][victimWay] <= 1'b0;    // Victim already queued
            end
            if (cacheHit) begin
                lruQ[reqSet] <= !hitWay;
                if (req.write) begin
                    dirtyQ[reqSet][hitWay] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (refill) begin
            tagMem[reqSet][victimWay]  <= reqTag;
            dataMem[reqSet][victimWay] <= memRData;
        end else if (cacheHit && req.write) begin
            dataMem[reqSet][hitWay] <= storeWord;
        end
    end

    // Buffer status comes from writeBuffer
    pushNotFull: assert property (@(posedge clk) disable iff (rst) push |-> !bufFull)
        else $error("dataCache push while write buffer full");

    // Fetch must not overtake a queued write
    fetchAfterDrain: assert property (
        @(posedge clk) disable iff (rst) (memRd && !isIo) |-> (bufEmpty && !$past(push)))
        else $error("dataCache refill with writes pending");

endmodule

// ==== loadAlign.sv ====
`timescale 1ns/100ps
`include "cache_consts.svh"

module loadAlign
    import cachePkg::*;
(
    input  logic [`DATA_WIDTH-1:0] word,
    input  logic [1:0]             byteOffset,
    input  accessSize              size,
    output logic [`DATA_WIDTH-1:0] data
);

    logic [7:0]  selByte;
    logic [15:0] selHalf;

    // Lane picked by the low address bits
    assign selByte = word[8*byteOffset +: 8];
    assign selHalf = byteOffset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (size)
            sizeByte: begin
                data = {{(`DATA_WIDTH-8){selByte[7]}}, selByte};
            end
            sizeByteU: begin
                data = {{(`DATA_WIDTH-8){1'b0}}, selByte};
            end
            sizeHalf: begin
                data = {{(`DATA_WIDTH-16){selHalf[15]}}, selHalf};
            end
            sizeHalfU: begin
                data = {{(`DATA_WIDTH-16){1'b0}}, selHalf};
            end
            sizeWord: begin
                data = word;
            end
            default: begin
                data = '0;    // Unsupported funct3
            end
        endcase
    end

endmodule

// ==== memSubsystem.sv ====
`timescale 1ns/100ps
`include "cache_consts.svh"

module memSubsystem
    import cachePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  cpuReq                  req,
    output logic                   stall,
    output logic                   hit,
    output logic [`DATA_WIDTH-1:0] loadData,
    output logic                   memRd,
    output logic [`DATA_WIDTH-1:0] memRAddr,
    input  logic [`DATA_WIDTH-1:0] memRData,
    output logic                   memWe,
    output logic [`DATA_WIDTH-1:0] memWAddr,
    output logic [`DATA_WIDTH-1:0] memWData,
    input  logic                   memReady
);

    logic    push;
    memWrite pushEntry;
    logic    pop;
    memWrite head;
    logic    bufNotEmpty;
    logic    bufFull;
    logic    bufEmpty;

    // Producer, cache and load aligner
    dataCache dataCache_inst (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .memRData  (memRData),
        .bufFull   (bufFull),
        .bufEmpty  (bufEmpty),
        .stall     (stall),
        .hit       (hit),
        .loadData  (loadData),
        .memRd     (memRd),
        .memRAddr  (memRAddr),
        .push      (push),
        .pushEntry (pushEntry)
    );

    writeBuffer #(
        .payloadT (memWrite)
    ) writeBuffer_inst (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .pushData (pushEntry),
        .pop      (pop),
        .head     (head),
        .notEmpty (bufNotEmpty),
        .full     (bufFull),
        .empty    (bufEmpty)
    );

    // Consumer, drains onto the memory write port
    memWriter memWriter_inst (
        .clk      (clk),
        .rst      (rst),
        .head     (head),
        .notEmpty (bufNotEmpty),
        .memReady (memReady),
        .pop      (pop),
        .memWe    (memWe),
        .memWAddr (memWAddr),
        .memWData (memWData)
    );

endmodule

// ==== memWriter.sv ====
`timescale 1ns/100ps
`include "cache_consts.svh"

module memWriter
    import cachePkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  memWrite                head,
    input  logic                   notEmpty,
    input  logic                   memReady,
    output logic                   pop,
    output logic                   memWe,
    output logic [`DATA_WIDTH-1:0] memWAddr,
    output logic [`DATA_WIDTH-1:0] memWData
);

    logic loadNext;

    // Port free now or freed on this edge
    assign loadNext = notEmpty && (!memWe || memReady);
    assign pop      = loadNext;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            memWe <= 1'b0;
        end else if (loadNext) begin
            memWe <= 1'b1;
        end else if (memReady) begin
            memWe <= 1'b0;    // Last write accepted
        end
    end

    // Holding register for the port
    always_ff @(posedge clk) begin
        if (loadNext) begin
            memWAddr <= head.addr;
            memWData <= head.data;
        end
    end

    // Memory may sample at any cycle of the wait
    portHold: assert property (
        @(posedge clk) disable iff (rst)
        (memWe && !memReady) |=> (memWe && $stable(memWAddr) && $stable(memWData)))
        else $error("memWriter changed write port before memReady");

endmodule

// ==== src.f ====
+incdir+.
cachePkg.sv
loadAlign.sv
dataCache.sv
writeBuffer.sv
memWriter.sv
memSubsystem.sv
tbMemSubsystem.sv

// ==== tbMemSubsystem.sv ====
`timescale 1ns/100ps
`include "cache_consts.svh"

module tbMemSubsystem
    import cachePkg::*;
();

    localparam int NumAccesses = 65;    // 65 accesses over the six tests
    localparam int CycleLimit  = 40 * NumAccesses;
    localparam logic [31:0] AddrA = 32'h0000_0104;    // Steps of 0x100 stay in set 1

    logic                   clk;
    logic                   rst;
    cpuReq                  req;
    logic                   stall;
    logic                   hit;
    logic [`DATA_WIDTH-1:0] loadData;
    logic                   memRd;
    logic [`DATA_WIDTH-1:0] memRAddr;
    logic [`DATA_WIDTH-1:0] memRData;
    logic                   memWe;
    logic [`DATA_WIDTH-1:0] memWAddr;
    logic [`DATA_WIDTH-1:0] memWData;
    logic                   memReady;

    logic [31:0] mem [logic [31:0]];       // Backing store, changed only by the write port
    logic [31:0] shadow [logic [31:0]];    // Word view the core should see
    memWrite     obsWr[$];
    memWrite     expWr[$];
    logic [31:0] refLine [`NUM_SETS][2];   // Word address held by each way
    bit          refValid [`NUM_SETS][2];
    bit          refDirty [`NUM_SETS][2];
    bit          refLru [`NUM_SETS];
    logic [31:0] lfsr = 32'hbadfe276;
    int          memGen = 0;
    int          cycles = 0;
    int          valueErrors = 0;
    int          otherErrors = 0;

    memSubsystem memSubsystem_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);    // Galois step
            val  = {val[30:0], lfsr[0]};
        end
        return val;
    endfunction

    // Untouched memory, every address bit shows up
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h5a3c96e1;
    endfunction

    function automatic logic [31:0] readMem(input logic [31:0] addr);
        return mem.exists(addr) ? mem[addr] : fillWord(addr);
    endfunction

    function automatic logic [31:0] shadowRead(input logic [31:0] addr);
        return shadow.exists(addr) ? shadow[addr] : fillWord(addr);
    endfunction

    function automatic logic [31:0] mergeStore(input logic [31:0] old, input logic [31:0] wd,
                                               input logic [1:0] off, input accessSize size);
        logic [31:0] mask;
        mask = (size == sizeWord) ? 32'hFFFFFFFF : ((size == sizeHalf) ? 32'hFFFF : 32'hFF);
        mask = mask << (8 * off);
        return (old & ~mask) | ((wd << (8 * off)) & mask);
    endfunction

    function automatic logic [31:0] extendLoad(input logic [31:0] word, input logic [1:0] off,
                                               input accessSize size);
        logic [31:0] lane;
        lane = word >> (8 * off);    // Selected lane at bit 0
        case (size)
            sizeByte:  return {{24{lane[7]}}, lane[7:0]};
            sizeByteU: return {24'h0, lane[7:0]};
            sizeHalf:  return {{16{lane[15]}}, lane[15:0]};
            sizeHalfU: return {16'h0, lane[15:0]};
            sizeWord:  return word;
            default:   return '0;
        endcase
    endfunction

    task automatic flagError(input string msg);
        $display("Error: %s", msg);
        otherErrors++;
    endtask

    task automatic compareWord(input string name, input logic [`DATA_WIDTH-1:0] got,
                               input logic [`DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got %08h, expected %08h", name, got, exp);
            valueErrors++;
        end
    endtask

    task automatic compareWrite(input memWrite got, input memWrite exp);
        compareWord("memWAddr", got.addr, exp.addr);
        compareWord("memWData", got.data, exp.data);
    endtask

    // Memory model, read side answers at once
    always @(memRAddr or memGen) begin
        memRData = readMem(memRAddr);
    end

    always @(posedge clk) begin
        if (memWe && memReady) begin
            obsWr.push_back(memWrite'({memWAddr, memWData}));
            mem[memWAddr] = memWData;
            memGen <= memGen + 1;    // Refresh read data after the edge
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == CycleLimit) begin
            $display("Timeout after %0d cycles", CycleLimit);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // One core access, reference cache model stepped alongside
    task automatic access(input logic [31:0] addr, input logic isWrite, input accessSize size,
                          input logic [31:0] wData, input int holdCycles);
        logic [31:0] wordAddr;
        logic [1:0]  set;
        logic        way;
        logic        expHit;
        logic        isIo;
        logic [31:0] expLoad;
        int          stalls;
        logic        sawRd;
        wordAddr = {addr[31:2], 2'b00};
        set      = addr[3:2];
        isIo     = (addr == `MMIO_ADDR);
        expHit   = 1'b0;
        expLoad  = extendLoad(isIo ? readMem(wordAddr) : shadowRead(wordAddr), addr[1:0], size);
        if (isIo && isWrite) begin
            expWr.push_back(memWrite'({wordAddr, wData}));
        end else if (!isIo) begin
            expHit = (refValid[set][0] && refLine[set][0] == wordAddr)
                  || (refValid[set][1] && refLine[set][1] == wordAddr);
            if (expHit) begin
                way = !(refValid[set][0] && refLine[set][0] == wordAddr);
            end else begin
                way = !refValid[set][0] ? 1'b0 : (!refValid[set][1] ? 1'b1 : refLru[set]);
                if (refValid[set][way] && refDirty[set][way]) begin
                    expWr.push_back(memWrite'({refLine[set][way], shadowRead(refLine[set][way])}));
                end
                refValid[set][way] = 1'b1;
                refDirty[set][way] = 1'b0;
                refLine[set][way]  = wordAddr;
            end
            refLru[set] = !way;
            if (isWrite) begin
                refDirty[set][way] = 1'b1;
                shadow[wordAddr]   = mergeStore(shadowRead(wordAddr), wData, addr[1:0], size);
            end
        end
        req.addr  = addr;
        req.wData = wData;
        req.write = isWrite;
        req.read  = !isWrite;
        req.size  = size;
        stalls    = 0;
        sawRd     = 1'b0;
        forever begin
            @(negedge clk);
            if (memRd) begin
                compareWord("memRAddr", memRAddr, wordAddr);
            end
            if (!stall) begin
                break;
            end
            stalls++;
            sawRd = sawRd || memRd;
            if (stalls == holdCycles) begin
                @(posedge clk);
                #1;
                memReady = 1'b1;    // Let the buffer drain
            end
        end
        if (holdCycles > 0 && stalls < holdCycles) begin
            flagError("stall fell while the write buffer was full");
        end
        if (isIo && (hit || (!isWrite && (!memRd || stalls != 0)))) begin
            flagError("I/O access hit the cache or missed its single-cycle read");
        end
        if (!isIo && (!hit || memRd)) begin
            flagError("cached access did not end on a hit without a fetch");
        end
        if (!isIo && expHit && stalls != 0) begin
            flagError("cache hit stalled");
        end
        if (!isIo && !expHit && (stalls == 0 || !sawRd)) begin
            flagError("cache miss did not stall and fetch the line");
        end
        if (!isWrite) begin
            compareWord("loadData", loadData, expLoad);
        end
        @(posedge clk);
        #1;
        req = '0;
    endtask

    // Expected writes in order, then a few idle cycles to catch extras
    task automatic drainWrites();
        while (obsWr.size() < expWr.size()) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        #1;
        if (obsWr.size() != expWr.size()) begin
            flagError($sformatf("write port carried %0d writes, %0d expected",
                                obsWr.size(), expWr.size()));
        end
        while (obsWr.size() > 0 && expWr.size() > 0) begin
            compareWrite(obsWr.pop_front(), expWr.pop_front());
        end
        obsWr.delete();
        expWr.delete();
    endtask

    task automatic resetState();
        @(negedge clk);
        if (stall || memRd || memWe) begin
            flagError("stall, memRd or memWe high after reset");
        end
        @(posedge clk);
        #1;
        access(AddrA, 1'b0, sizeWord, '0, 0);    // Cold miss
    endtask

    task automatic fillLoads();
        for (int o = 0; o < 4; o++) begin
            access(AddrA + o, 1'b0, sizeByte, '0, 0);
            access(AddrA + o, 1'b0, sizeByteU, '0, 0);
        end
        for (int o = 0; o < 4; o += 2) begin
            access(AddrA + o, 1'b0, sizeHalf, '0, 0);
            access(AddrA + o, 1'b0, sizeHalfU, '0, 0);
        end
        access(AddrA, 1'b0, sizeWord, '0, 0);
    endtask

    task automatic storeMerge();
        logic [31:0] base;
        access(AddrA + 32'h100, 1'b0, sizeWord, '0, 0);    // Second word into way 1
        for (int w = 0; w < 2; w++) begin
            base = AddrA + 32'h100 * w;
            for (int o = 0; o < 4; o++) begin
                access(base + o, 1'b1, sizeByte, randBits(8), 0);
                access(base, 1'b0, sizeWord, '0, 0);
            end
            for (int o = 0; o < 4; o += 2) begin
                access(base + o, 1'b1, sizeHalf, randBits(16), 0);
                access(base, 1'b0, sizeWord, '0, 0);
            end
            access(base, 1'b1, sizeWord, randBits(32), 0);
            access(base, 1'b0, sizeWord, '0, 0);
            compareWord("mem", readMem(base), fillWord(base));    // Still only in the cache
        end
        drainWrites();
    endtask

    task automatic evictLru();
        access(AddrA + 32'h200, 1'b0, sizeWord, '0, 0);
        access(AddrA + 32'h300, 1'b1, sizeWord, randBits(32), 0);
        for (int k = 1; k < 4; k++) begin
            access(32'h108 + 32'h100 * k, 1'b0, sizeHalfU, '0, 0);    // Last one evicts clean
        end
        drainWrites();
        access(AddrA, 1'b0, sizeWord, '0, 0);    // Written back word comes home
    endtask

    task automatic backPressure();
        memReady = 1'b0;
        for (int k = 1; k < 5; k++) begin
            access(32'h100 * k, 1'b1, sizeWord, randBits(32), 0);
        end
        for (int k = 0; k < 3; k++) begin
            access(`MMIO_ADDR, 1'b1, sizeWord, randBits(32), 0);
        end
        access(`MMIO_ADDR, 1'b1, sizeWord, randBits(32), 10);    // Buffer full here
        drainWrites();
        access(32'h100, 1'b0, sizeWord, '0, 0);
        drainWrites();
    endtask

    task automatic ioBypass();
        logic [31:0] ioWord;
        ioWord = randBits(32);
        access(`MMIO_ADDR, 1'b0, sizeWord, '0, 0);
        access(32'h1FC, 1'b0, sizeWord, '0, 0);    // Both ways of the I/O set
        access(32'h2FC, 1'b0, sizeWord, '0, 0);
        access(`MMIO_ADDR, 1'b1, sizeWord, ioWord, 0);
        drainWrites();
        compareWord("mem", readMem(`MMIO_ADDR), ioWord);
        access(`MMIO_ADDR, 1'b0, sizeByte, '0, 0);
        access(32'h1FC, 1'b0, sizeWord, '0, 0);    // Lines untouched by the I/O store
        access(32'h2FC, 1'b0, sizeWord, '0, 0);
    endtask

    initial begin
        rst      = 1'b1;
        req      = '0;
        memReady = 1'b1;
        memRData = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        resetState();
        fillLoads();
        storeMerge();
        evictLru();
        backPressure();
        ioBypass();
        $display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== writeBuffer.sv ====
`timescale 1ns/100ps
`include "cache_consts.svh"

module writeBuffer #(
    parameter type payloadT = logic [63:0]
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    push,
    input  payloadT pushData,
    input  logic    pop,
    output payloadT head,
    output logic    notEmpty,
    output logic    full,
    output logic    empty
);

    localparam int PtrBits = $clog2(`WB_DEPTH);

    payloadT slots [`WB_DEPTH];

    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [PtrBits:0]   count;
    logic               doPush;
    logic               doPop;

    // Wrap explicitly so any depth works
    function automatic logic [PtrBits-1:0] nextPtr(input logic [PtrBits-1:0] ptr);
        logic [PtrBits-1:0] nxt;
        nxt = (ptr == PtrBits'(`WB_DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    assign doPush   = push && !full;
    assign doPop    = pop && !empty;
    assign full     = (count == (PtrBits+1)'(`WB_DEPTH));
    assign empty    = (count == '0);
    assign notEmpty = !empty;
    assign head     = slots[rdPtr];    // Oldest entry

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            slots[wrPtr] <= pushData;
        end
    end

    // Writer must only pop what is there
    popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("writeBuffer pop while empty");

endmodule
